// File: files.f
+incdir+common
common/imem_pkg.sv
hw/apb_debug_port.sv
hw/instr_mem.sv
hw/fetch_unit.sv
hw/imem_fetch_top.sv
verif/imem_fetch_props.sv
verif/tb_imem_fetch.sv

// File: run_sim.sh
#!/bin/sh
# build and run the instruction fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_imem_fetch
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_imem_fetch > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

// File: verif/tb_imem_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "imem_cfg.svh"

module tb_imem_fetch;
    import imem_pkg::*;

    localparam int NPROG = 16;                          // program length with the halt word

    logic       i_WriteDebug;
    logic       i_reset;
    apb_req_t   i_apb;
    logic       i_ready;
    apb_rsp_t   o_apb;
    fetch_out_t o_fetch;

    integer     seed;
    int         errors;
    instr_t     prog [NPROG];
    instr_t     model [`IMEM_WORDS];                    // expected memory contents

    imem_fetch_top imem_fetch_top_inst
    (
        .i_WriteDebug (i_WriteDebug),
        .i_reset      (i_reset),
        .i_apb        (i_apb),
        .i_ready      (i_ready),
        .o_apb        (o_apb),
        .o_fetch      (o_fetch)
    );

    bind imem_fetch_top imem_fetch_props imem_fetch_props_inst
    (
        .i_WriteDebug (i_WriteDebug),
        .i_reset      (i_reset),
        .i_apb        (i_apb),
        .i_ready      (i_ready),
        .o_apb        (o_apb),
        .o_fetch      (o_fetch)
    );

    always
    begin
        #50;
        i_WriteDebug = ~i_WriteDebug;
    end

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp)
        else
        begin
            errors++;
            $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // setup cycle, then access cycle, response sampled mid access
    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        i_apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge i_WriteDebug);
        #1;
        i_apb.penable = 1'b1;
        @(negedge i_WriteDebug);
        err = o_apb.pslverr;
        @(posedge i_WriteDebug);
        #1;
        i_apb = '0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata, output logic err);
        i_apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
        @(posedge i_WriteDebug);
        #1;
        i_apb.penable = 1'b1;
        @(negedge i_WriteDebug);
        rdata = o_apb.prdata;
        err   = o_apb.pslverr;
        @(posedge i_WriteDebug);
        #1;
        i_apb = '0;
    endtask

    task automatic take_beat(input bit random_ready, output fetch_out_t beat, output bit ok);
        logic [31:0] rnd;
        ok = 1'b0;
        for (int n = 0; n < 200 && !ok; n++)
        begin
            rnd     = $random(seed);
            i_ready = random_ready ? rnd[0] : 1'b1;
            @(negedge i_WriteDebug);
            if (o_fetch.valid && i_ready)
            begin
                beat = o_fetch;                         // accepted on the coming edge
                ok   = 1'b1;
            end
            @(posedge i_WriteDebug);
            #1;
        end
        if (!ok)
        begin
            errors++;
            $display("Timed out after 200 cycles waiting for an instruction beat");
        end
    endtask

    task automatic expect_idle(input int cycles);
        for (int n = 0; n < cycles; n++)
        begin
            @(negedge i_WriteDebug);
            check_word(32'(o_fetch.valid), 32'd0, "valid while fetch is not running");
            @(posedge i_WriteDebug);
            #1;
        end
    endtask

    task automatic read_word(input int idx, output logic [31:0] rdata, output logic err);
        apb_write(`REG_ADDR, 32'(idx * 4), err);
        apb_read(`REG_DATA, rdata, err);
    endtask

    task automatic verify_memory(input string what);
        logic [31:0] rdata;
        logic        err;
        for (int i = 0; i < `IMEM_WORDS; i++)
        begin
            read_word(i, rdata, err);
            check_word(rdata, model[i], $sformatf("%s, word %0d", what, i));
            check_word(32'(err), 32'd0, "pslverr on debug read");
        end
    endtask

    task automatic test_reset_state();
        logic [31:0] rdata;
        logic        err;
        apb_read(`REG_STATUS, rdata, err);
        check_word({30'd0, rdata[1:0]}, 32'd0, "status flags after reset");
        for (int i = 0; i < `IMEM_WORDS; i += 13)       // words 0, 13, 26, 39
        begin
            read_word(i, rdata, err);
            check_word(rdata, 32'd0, $sformatf("word %0d after reset", i));
        end
    endtask

    task automatic test_load_readback();
        logic [31:0] rdata;
        logic        err;
        apb_write(`REG_ADDR, 32'd0, err);
        for (int i = 0; i < NPROG; i++)
        begin
            apb_write(`REG_DATA, prog[i], err);         // addr steps by 4 on its own
            check_word(32'(err), 32'd0, "pslverr on program load");
            model[i] = prog[i];
        end
        apb_read(`REG_ADDR, rdata, err);
        check_word(rdata, 32'(NPROG * 4), "addr after load burst");
        verify_memory("read back of loaded program");
    endtask

    task automatic test_fetch_backpressure();
        fetch_out_t  beat;
        bit          ok;
        logic [31:0] rdata;
        logic        err;
        apb_write(`REG_CTRL, 32'h1, err);
        for (int i = 0; i < NPROG; i++)
        begin
            take_beat(1'b1, beat, ok);
            if (!ok)
                break;
            check_word(beat.pc, 32'(i * 4), "pc of accepted beat");
            check_word(beat.instr, prog[i], "instr of accepted beat");
        end
        i_ready = 1'b1;
        expect_idle(4);                                 // nothing after the halt beat
        apb_read(`REG_STATUS, rdata, err);
        check_word({30'd0, rdata[1:0]}, 32'd2, "status flags after halt");
        check_word({8'd0, rdata[31:8]}, 32'(NPROG * 4), "status pc after halt");
    endtask

    task automatic test_error_cases();
        logic [31:0] rdata;
        logic        err;
        apb_write(`REG_ADDR, 32'(`IMEM_WORDS * 4), err);
        apb_write(`REG_DATA, 32'h5a5a_0001, err);
        check_word(32'(err), 32'd1, "pslverr on data write out of range");
        apb_read(`REG_ADDR, rdata, err);
        check_word(rdata, 32'(`IMEM_WORDS * 4), "addr after refused write");
        apb_write(`REG_STATUS, 32'h3, err);
        check_word(32'(err), 32'd1, "pslverr on status write");
        i_ready = 1'b0;                                 // keep the first beat stalled
        apb_write(`REG_CTRL, 32'h1, err);
        apb_read(`REG_STATUS, rdata, err);
        check_word({30'd0, rdata[1:0]}, 32'd1, "status flags while running");
        apb_write(`REG_ADDR, 32'h8, err);
        apb_write(`REG_DATA, 32'h5a5a_0002, err);
        check_word(32'(err), 32'd1, "pslverr on data write while running");
        apb_write(`REG_CTRL, 32'h2, err);
        verify_memory("memory after refused writes");
    endtask

    task automatic test_stop_restart();
        fetch_out_t  beat;
        bit          ok;
        logic [31:0] rdata;
        logic        err;
        apb_write(`REG_CTRL, 32'h1, err);
        for (int i = 0; i < 5; i++)
        begin
            take_beat(1'b0, beat, ok);
            check_word(beat.pc, 32'(i * 4), "pc before stop");
        end
        i_ready = 1'b0;                                 // stop with a beat pending
        apb_write(`REG_CTRL, 32'h2, err);
        expect_idle(2);
        apb_read(`REG_STATUS, rdata, err);
        check_word({30'd0, rdata[1:0]}, 32'd0, "status flags after stop");
        apb_write(`REG_CTRL, 32'h1, err);
        @(negedge i_WriteDebug);
        check_word(32'(o_fetch.valid), 32'd1, "valid after restart");
        check_word(o_fetch.pc, 32'd0, "pc after restart");
        check_word(o_fetch.instr, prog[0], "instr after restart");
        @(posedge i_WriteDebug);
        #1;
        apb_write(`REG_CTRL, 32'h2, err);
    endtask

    initial
    begin
        seed         = 86581;
        errors       = 0;
        i_WriteDebug = 1'b0;
        i_reset      = 1'b1;
        i_apb        = '0;
        i_ready      = 1'b0;
        for (int i = 0; i < `IMEM_WORDS; i++)
            model[i] = '0;
        for (int i = 0; i < NPROG - 1; i++)
        begin
            prog[i] = $random(seed);
            if (prog[i] == `IMEM_HALT_WORD)
                prog[i] = 32'd0;                        // only the last word may halt
        end
        prog[NPROG-1] = `IMEM_HALT_WORD;
        repeat (3) @(posedge i_WriteDebug);
        #1;
        i_reset = 1'b0;
        test_reset_state();
        test_load_readback();
        test_fetch_backpressure();
        test_error_cases();
        test_stop_restart();
        $display("Checks finished with %0d errors", errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/imem_fetch_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "imem_cfg.svh"

module imem_fetch_props
(
    input wire logic                 i_WriteDebug,
    input wire logic                 i_reset,
    input wire imem_pkg::apb_req_t   i_apb,
    input wire logic                 i_ready,
    input wire imem_pkg::apb_rsp_t   o_apb,
    input wire imem_pkg::fetch_out_t o_fetch
);
    logic ctrl_wr;

    // start and stop may end a stalled beat
    assign ctrl_wr = i_apb.psel && i_apb.penable && i_apb.pwrite && i_apb.paddr == `REG_CTRL;

    a_pready: assert property (@(posedge i_WriteDebug) o_apb.pready)
        else $error("pready low");

    a_stall: assert property (@(posedge i_WriteDebug) disable iff (i_reset)
        o_fetch.valid && !i_ready && !ctrl_wr
        |=> o_fetch.valid && $stable(o_fetch.pc) && $stable(o_fetch.instr))
        else $error("stalled beat changed");

    a_pc_align: assert property (@(posedge i_WriteDebug) disable iff (i_reset)
        o_fetch.pc[1:0] == 2'b00)
        else $error("pc not word aligned");

    a_reset_valid: assert property (@(posedge i_WriteDebug) i_reset |=> !o_fetch.valid)
        else $error("valid high after reset");

endmodule

`default_nettype wire

// File: hw/imem_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "imem_cfg.svh"

module imem_fetch_top
(
    input  wire logic               i_WriteDebug,
    input  wire logic               i_reset,
    input  wire imem_pkg::apb_req_t i_apb,
    input  wire logic               i_ready,
    output imem_pkg::apb_rsp_t      o_apb,
    output imem_pkg::fetch_out_t    o_fetch
);
    import imem_pkg::*;

    mem_wr_t     mem_wr;                                // apb store to memory
    mem_idx_t    dbg_idx;
    mem_idx_t    fetch_idx;
    instr_t      dbg_word;
    instr_t      fetch_word;
    fetch_cmd_t  cmd;                                   // start and stop pulses
    fetch_stat_t stat;

    apb_debug_port apb_debug_port_inst
    (
        .i_WriteDebug (i_WriteDebug),
        .i_reset      (i_reset),
        .i_apb        (i_apb),
        .i_dbg_word   (dbg_word),
        .i_stat       (stat),
        .o_apb        (o_apb),
        .o_mem_wr     (mem_wr),
        .o_dbg_idx    (dbg_idx),
        .o_cmd        (cmd)
    );

    instr_mem
    #(
        .WORDS (`IMEM_WORDS)
    )
    instr_mem_inst
    (
        .i_WriteDebug (i_WriteDebug),
        .i_reset      (i_reset),
        .i_wr         (mem_wr),
        .i_fetch_idx  (fetch_idx),
        .i_dbg_idx    (dbg_idx),
        .o_fetch_word (fetch_word),
        .o_dbg_word   (dbg_word)
    );

    fetch_unit fetch_unit_inst
    (
        .i_WriteDebug (i_WriteDebug),
        .i_reset      (i_reset),
        .i_cmd        (cmd),
        .i_word       (fetch_word),
        .i_ready      (i_ready),
        .o_fetch_idx  (fetch_idx),
        .o_fetch      (o_fetch),
        .o_stat       (stat)
    );

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "imem_cfg.svh"

module fetch_unit
(
    input  wire logic                 i_WriteDebug,
    input  wire logic                 i_reset,
    input  wire imem_pkg::fetch_cmd_t i_cmd,
    input  wire imem_pkg::instr_t     i_word,
    input  wire logic                 i_ready,
    output imem_pkg::mem_idx_t        o_fetch_idx,
    output imem_pkg::fetch_out_t      o_fetch,
    output imem_pkg::fetch_stat_t     o_stat
);
    import imem_pkg::*;

    localparam pc_t LAST_PC = pc_t'((`IMEM_WORDS - 1) * 4);

    fetch_state_e state_q;
    fetch_state_e state_d;
    pc_t          pc_q;
    pc_t          pc_d;
    logic         beat_done;
    logic         is_halt;

    assign beat_done = (state_q == FS_RUN) && i_ready;  // beat accepted downstream
    assign is_halt   = i_word == `IMEM_HALT_WORD;

    always_comb
    begin
        state_d = state_q;
        pc_d    = pc_q;
        if (i_cmd.stop)
        begin
            state_d = FS_IDLE;                          // drops any pending beat
        end
        else if (i_cmd.start)
        begin
            state_d = FS_RUN;
            pc_d    = '0;
        end
        else if (beat_done)
        begin
            pc_d = (pc_q == LAST_PC) ? '0 : pc_q + pc_t'(4);
            if (is_halt)
            begin
                state_d = FS_HALTED;
            end
        end
    end

    always_ff @(posedge i_WriteDebug)
    begin
        if (i_reset)
        begin
            state_q <= FS_IDLE;
            pc_q    <= '0;
        end
        else
        begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    assign o_fetch_idx = mem_idx_t'(pc_q >> 2);         // byte to word address

    assign o_fetch.valid = state_q == FS_RUN;
    assign o_fetch.pc    = pc_q;
    assign o_fetch.instr = i_word;                      // held while pc holds

    assign o_stat.running = state_q == FS_RUN;
    assign o_stat.halted  = state_q == FS_HALTED;
    assign o_stat.pc      = pc_q;

endmodule

`default_nettype wire

// File: hw/instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "imem_cfg.svh"

module instr_mem
#(
    parameter int WORDS = `IMEM_WORDS
)
(
    input  wire logic               i_WriteDebug,
    input  wire logic               i_reset,
    input  wire imem_pkg::mem_wr_t  i_wr,
    input  wire imem_pkg::mem_idx_t i_fetch_idx,
    input  wire imem_pkg::mem_idx_t i_dbg_idx,
    output imem_pkg::instr_t        o_fetch_word,
    output imem_pkg::instr_t        o_dbg_word
);
    import imem_pkg::*;

    instr_t mem [WORDS];

    // whole array is wiped on reset
    always_ff @(posedge i_WriteDebug)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < WORDS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (i_wr.en && int'(i_wr.idx) < WORDS)
        begin
            mem[i_wr.idx] <= i_wr.data;
        end
    end

    // two independent async read ports
    assign o_fetch_word = (int'(i_fetch_idx) < WORDS) ? mem[i_fetch_idx] : '0;
    assign o_dbg_word   = (int'(i_dbg_idx) < WORDS) ? mem[i_dbg_idx] : '0;

endmodule

`default_nettype wire

// File: hw/apb_debug_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "imem_cfg.svh"

module apb_debug_port
(
    input  wire logic                  i_WriteDebug,
    input  wire logic                  i_reset,
    input  wire imem_pkg::apb_req_t    i_apb,
    input  wire imem_pkg::instr_t      i_dbg_word,
    input  wire imem_pkg::fetch_stat_t i_stat,
    output imem_pkg::apb_rsp_t         o_apb,
    output imem_pkg::mem_wr_t          o_mem_wr,
    output imem_pkg::mem_idx_t         o_dbg_idx,
    output imem_pkg::fetch_cmd_t       o_cmd
);
    import imem_pkg::*;

    localparam pc_t ADDR_LIMIT = pc_t'(`IMEM_WORDS * 4);

    pc_t  addr_q;                                       // debug byte address
    logic access;
    logic wr_access;
    logic sel_ctrl;
    logic sel_addr;
    logic sel_data;
    logic sel_status;
    logic addr_ok;
    logic err;

    assign access     = i_apb.psel && i_apb.penable;    // second cycle of a transfer
    assign wr_access  = access && i_apb.pwrite;
    assign sel_ctrl   = i_apb.paddr == `REG_CTRL;
    assign sel_addr   = i_apb.paddr == `REG_ADDR;
    assign sel_data   = i_apb.paddr == `REG_DATA;
    assign sel_status = i_apb.paddr == `REG_STATUS;
    assign addr_ok    = addr_q < ADDR_LIMIT;

    // refused accesses leave memory and addr alone
    assign err = access && ((sel_data && !addr_ok)
                         || (sel_data && i_apb.pwrite && i_stat.running)
                         || (sel_status && i_apb.pwrite));

    always_ff @(posedge i_WriteDebug)
    begin
        if (i_reset)
        begin
            addr_q <= '0;
        end
        else if (wr_access && !err)
        begin
            if (sel_addr)
            begin
                addr_q <= i_apb.pwdata;
            end
            else if (sel_data)
            begin
                addr_q <= addr_q + pc_t'(4);            // auto-increment after a store
            end
        end
    end

    assign o_dbg_idx = mem_idx_t'(addr_q >> 2);

    assign o_mem_wr.en   = wr_access && sel_data && !err;
    assign o_mem_wr.idx  = o_dbg_idx;
    assign o_mem_wr.data = i_apb.pwdata;

    assign o_cmd.start = wr_access && sel_ctrl && i_apb.pwdata[0];
    assign o_cmd.stop  = wr_access && sel_ctrl && i_apb.pwdata[1];

    always_comb
    begin
        o_apb.prdata = '0;
        if (access && !i_apb.pwrite && !err)
        begin
            case (i_apb.paddr)
                `REG_ADDR:   o_apb.prdata = addr_q;
                `REG_DATA:   o_apb.prdata = i_dbg_word;
                `REG_STATUS: o_apb.prdata = {i_stat.pc[23:0], 6'b0,
                                             i_stat.halted, i_stat.running};
                default:     o_apb.prdata = '0;    // ctrl reads as zero
            endcase
        end
    end

    assign o_apb.pready  = 1'b1;                        // no wait states
    assign o_apb.pslverr = err;

endmodule

`default_nettype wire

// File: common/imem_pkg.sv
`default_nettype none

`include "imem_cfg.svh"

package imem_pkg;

    typedef logic [`IMEM_WIDTH-1:0]          instr_t;
    typedef logic [31:0]                     pc_t;      // byte address
    typedef logic [$clog2(`IMEM_WORDS)-1:0]  mem_idx_t; // word index

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic     en;
        mem_idx_t idx;
        instr_t   data;
    } mem_wr_t;

    typedef struct packed {
        logic start;                                    // one-cycle pulses
        logic stop;
    } fetch_cmd_t;

    typedef struct packed {
        logic running;
        logic halted;
        pc_t  pc;
    } fetch_stat_t;

    typedef struct packed {
        logic   valid;
        pc_t    pc;
        instr_t instr;
    } fetch_out_t;

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_RUN,
        FS_HALTED
    } fetch_state_e;

endpackage

`default_nettype wire

// File: common/imem_cfg.svh
`ifndef IMEM_CFG_SVH
`define IMEM_CFG_SVH

// instruction word and program memory size
`define IMEM_WIDTH      32
`define IMEM_WORDS      40                      // 160 bytes of program

// fetch stops after delivering this word
`define IMEM_HALT_WORD  {`IMEM_WIDTH{1'b1}}

// apb register byte offsets
`define REG_CTRL        4'h0                    // bit 0 start, bit 1 stop
`define REG_ADDR        4'h4                    // debug byte address
`define REG_DATA        4'h8                    // memory word at addr
`define REG_STATUS      4'hC                    // running, halted, pc

`endif
